/* compile.f */
+incdir+rtl
rtl/exe_pkg.sv
rtl/exe_alu.sv
rtl/store_align.sv
rtl/exe_pipe_reg.sv
rtl/execute_stage.sv
verif/tb_execute_stage.sv

/* rtl/exe_alu.sv */
// Purely combinational; overflow is flagged only for signed add and sub, never for shifts or logic
`timescale 1ns/1ps
`default_nettype none

`include "exe_params.svh"

module exe_alu (
  input  wire exe_pkg::id_exe_t id,
  output exe_pkg::word_t        result,
  output logic                  overflow
);

  localparam int msb = `EXE_WORD_W - 1;

  exe_pkg::word_t op_a;
  exe_pkg::word_t op_b;
  exe_pkg::word_t sum;
  exe_pkg::word_t diff;
  logic [4:0]     shamt;
  logic           add_ovf;
  logic           sub_ovf;

  ////////////////////////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (id.src_a)
      `EXE_SRCA_RS:   op_a = id.rs_data;
      `EXE_SRCA_PC4:  op_a = id.pc_plus4;
      `EXE_SRCA_SA:   op_a = id.sa;
      `EXE_SRCA_ZERO: op_a = '0;
      default:        op_a = '0;
    endcase
  end

  always_comb begin
    case (id.src_b)
      `EXE_SRCB_RT:   op_b = id.rt_data;
      `EXE_SRCB_SEXT: op_b = id.sext_imm;
      `EXE_SRCB_FOUR: op_b = exe_pkg::word_t'(4);
      `EXE_SRCB_ZEXT: op_b = id.zext_imm;
      default:        op_b = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Arithmetic and logic
  ////////////////////////////////////////////////////////////

  assign sum   = op_a + op_b;
  assign diff  = op_a - op_b;
  // Shift amount rides in A, the value to shift in B
  assign shamt = op_a[4:0];

  always_comb begin
    case (id.alu_op)
      `EXE_ALU_ADD:  result = sum;
      `EXE_ALU_SUB:  result = diff;
      `EXE_ALU_AND:  result = op_a & op_b;
      `EXE_ALU_OR:   result = op_a | op_b;
      `EXE_ALU_XOR:  result = op_a ^ op_b;
      `EXE_ALU_NOR:  result = ~(op_a | op_b);
      `EXE_ALU_SLT:  result = exe_pkg::word_t'($signed(op_a) < $signed(op_b));
      `EXE_ALU_SLTU: result = exe_pkg::word_t'(op_a < op_b);
      `EXE_ALU_SLL:  result = op_b << shamt;
      `EXE_ALU_SRL:  result = op_b >> shamt;
      `EXE_ALU_SRA:  result = exe_pkg::word_t'($signed(op_b) >>> shamt);
      `EXE_ALU_LUI:  result = op_b << 16;
      default:       result = '0;
    endcase
  end

  // Same-sign inputs for add, opposite signs for sub, and the result sign flips
  assign add_ovf  = (op_a[msb] == op_b[msb]) && (sum[msb] != op_a[msb]);
  assign sub_ovf  = (op_a[msb] != op_b[msb]) && (diff[msb] != op_a[msb]);
  assign overflow = id.is_signed &&
                    (((id.alu_op == `EXE_ALU_ADD) && add_ovf) ||
                     ((id.alu_op == `EXE_ALU_SUB) && sub_ovf));

endmodule

`default_nettype wire

/* rtl/exe_params.svh */
// Encodings shared with decode; a 32-bit little-endian datapath with 5-bit register numbers
`ifndef EXE_PARAMS_SVH
`define EXE_PARAMS_SVH

`define EXE_WORD_W      32
`define EXE_REG_ADDR_W  5
`define EXE_ALU_OP_W    4

// ALU opcodes
`define EXE_ALU_ADD   4'd0
`define EXE_ALU_SUB   4'd1
`define EXE_ALU_AND   4'd2
`define EXE_ALU_OR    4'd3
`define EXE_ALU_XOR   4'd4
`define EXE_ALU_NOR   4'd5
`define EXE_ALU_SLT   4'd6
`define EXE_ALU_SLTU  4'd7
`define EXE_ALU_SLL   4'd8
`define EXE_ALU_SRL   4'd9
`define EXE_ALU_SRA   4'd10
`define EXE_ALU_LUI   4'd11

// Operand selects
`define EXE_SRCA_RS    2'd0
`define EXE_SRCA_PC4   2'd1
`define EXE_SRCA_SA    2'd2
`define EXE_SRCA_ZERO  2'd3
`define EXE_SRCB_RT    2'd0
`define EXE_SRCB_SEXT  2'd1
`define EXE_SRCB_FOUR  2'd2
`define EXE_SRCB_ZEXT  2'd3

// Memory access kinds
`define EXE_ST_NONE  2'd0
`define EXE_ST_B     2'd1
`define EXE_ST_H     2'd2
`define EXE_ST_W     2'd3
`define EXE_LD_NONE  3'd0
`define EXE_LD_B     3'd1
`define EXE_LD_BU    3'd2
`define EXE_LD_H     3'd3
`define EXE_LD_HU    3'd4
`define EXE_LD_W     3'd5

`endif

/* rtl/exe_pipe_reg.sv */
// One-entry stage register; accepts new work in the cycle the held item leaves, no bubble
`timescale 1ns/1ps
`default_nettype none

module exe_pipe_reg (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    in_valid,
  output logic                   allowin,
  input  wire exe_pkg::exe_mem_t in_data,
  output logic                   out_valid,
  input  wire                    mem_allowin,
  output exe_pkg::exe_mem_t      out_data
);

  logic accept;

  // Empty, or the held item leaves on this edge
  assign allowin = !out_valid || mem_allowin;
  assign accept  = in_valid && allowin;

  ////////////////////////////////////////////////////////////
  // Valid bit and result register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (allowin) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_data <= '0;
    end else if (accept) begin
      out_data <= in_data;
    end
  end

  // A stalled item stays put and stays valid until the memory stage takes it
  a_hold_on_stall : assert property (
    @(posedge clk) disable iff (rst)
    (out_valid && !mem_allowin) |=> (out_valid && $stable(out_data))
  ) else $error("exe_pipe_reg: output changed while stalled");

endmodule

`default_nettype wire

/* rtl/exe_pkg.sv */
// Field widths come from exe_params.svh, so the rtl folder must be on the include path
`default_nettype none

`include "exe_params.svh"

package exe_pkg;

  typedef logic [`EXE_WORD_W-1:0]     word_t;
  typedef logic [`EXE_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`EXE_ALU_OP_W-1:0]   alu_op_t;
  typedef logic [1:0]                 src_sel_t;
  typedef logic [1:0]                 store_kind_t;
  typedef logic [2:0]                 load_kind_t;
  typedef logic [3:0]                 byte_en_t;
  // 0 byte, 1 half, 2 word
  typedef logic [2:0]                 acc_size_t;

  // Exception flags raised in decode
  typedef struct packed {
    logic pc_adel;
    logic reserved_instr;
    logic syscall;
    logic brk;
  } id_exc_t;

  // Vector toward the memory stage, high bit first
  typedef struct packed {
    logic pc_adel;
    logic reserved_instr;
    logic overflow;
    logic syscall;
    logic brk;
    logic adel;
    logic ades;
  } exc_vec_t;

  ////////////////////////////////////////////////////////////
  // Stage bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    word_t       pc;
    word_t       pc_plus4;
    word_t       rs_data;
    word_t       rt_data;
    word_t       sa;
    word_t       sext_imm;
    word_t       zext_imm;
    src_sel_t    src_a;
    src_sel_t    src_b;
    alu_op_t     alu_op;
    logic        is_signed;
    store_kind_t store_kind;
    load_kind_t  load_kind;
    logic        mem_en;
    logic        mem_to_reg;
    logic [3:0]  reg_wen;
    reg_addr_t   reg_waddr;
    logic        delay_slot;
    id_exc_t     id_exc;
  } id_exe_t;

  typedef struct packed {
    word_t      pc;
    word_t      alu_result;
    word_t      mem_wdata;
    word_t      rt_data;
    byte_en_t   byte_en;
    logic [1:0] addr_lo;
    acc_size_t  acc_size;
    logic       mem_en;
    logic       mem_to_reg;
    logic [3:0] reg_wen;
    reg_addr_t  reg_waddr;
    load_kind_t load_kind;
    logic       delay_slot;
    exc_vec_t   exc;
  } exe_mem_t;

endpackage

`default_nettype wire

/* rtl/execute_stage.sv */
// No interrupt or eret squash, no CP0 or HI/LO; the exception vector is passed on, not acted on
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    in_valid,
  output logic                   allowin,
  input  wire exe_pkg::id_exe_t  id_in,
  output logic                   out_valid,
  input  wire                    mem_allowin,
  output exe_pkg::exe_mem_t      mem_out
);

  exe_pkg::word_t     alu_result;
  logic               overflow;
  exe_pkg::byte_en_t  byte_en;
  exe_pkg::word_t     mem_wdata;
  exe_pkg::acc_size_t acc_size;
  logic               adel;
  logic               ades;
  exe_pkg::exc_vec_t  exc;
  exe_pkg::exe_mem_t  stage_data;

  exe_alu i_alu (
    .id       (id_in),
    .result   (alu_result),
    .overflow (overflow)
  );

  store_align i_store_align (
    .addr_lo    (alu_result[1:0]),
    .store_kind (id_in.store_kind),
    .load_kind  (id_in.load_kind),
    .rt_data    (id_in.rt_data),
    .byte_en    (byte_en),
    .wdata      (mem_wdata),
    .size       (acc_size),
    .adel       (adel),
    .ades       (ades)
  );

  ////////////////////////////////////////////////////////////
  // Exception vector and result bundle
  ////////////////////////////////////////////////////////////

  always_comb begin
    exc.pc_adel        = id_in.id_exc.pc_adel;
    exc.reserved_instr = id_in.id_exc.reserved_instr;
    exc.overflow       = overflow;
    exc.syscall        = id_in.id_exc.syscall;
    exc.brk            = id_in.id_exc.brk;
    exc.adel           = adel;
    exc.ades           = ades;
  end

  always_comb begin
    stage_data.pc         = id_in.pc;
    stage_data.alu_result = alu_result;
    stage_data.mem_wdata  = mem_wdata;
    stage_data.rt_data    = id_in.rt_data;
    stage_data.byte_en    = byte_en;
    stage_data.addr_lo    = alu_result[1:0];
    stage_data.acc_size   = acc_size;
    stage_data.mem_en     = id_in.mem_en;
    stage_data.mem_to_reg = id_in.mem_to_reg;
    stage_data.reg_wen    = id_in.reg_wen;
    stage_data.reg_waddr  = id_in.reg_waddr;
    // Load kind goes through untouched, the memory stage extends the data
    stage_data.load_kind  = id_in.load_kind;
    stage_data.delay_slot = id_in.delay_slot;
    stage_data.exc        = exc;
  end

  exe_pipe_reg i_pipe_reg (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .allowin     (allowin),
    .in_data     (stage_data),
    .out_valid   (out_valid),
    .mem_allowin (mem_allowin),
    .out_data    (mem_out)
  );

endmodule

`default_nettype wire

/* rtl/store_align.sv */
// SB, SH and SW only; size follows the store, else the load, and is zero with no memory access
`timescale 1ns/1ps
`default_nettype none

`include "exe_params.svh"

module store_align (
  input  wire [1:0]                 addr_lo,
  input  wire exe_pkg::store_kind_t store_kind,
  input  wire exe_pkg::load_kind_t  load_kind,
  input  wire exe_pkg::word_t       rt_data,
  output exe_pkg::byte_en_t         byte_en,
  output exe_pkg::word_t            wdata,
  output exe_pkg::acc_size_t        size,
  output logic                      adel,
  output logic                      ades
);

  logic ld_half;
  logic ld_word;
  logic st_half;
  logic st_word;

  ////////////////////////////////////////////////////////////
  // Lane placement
  ////////////////////////////////////////////////////////////

  always_comb begin
    byte_en = '0;
    wdata   = '0;
    case (store_kind)
      `EXE_ST_B: begin
        byte_en = exe_pkg::byte_en_t'(4'b0001 << addr_lo);
        wdata   = exe_pkg::word_t'(rt_data[7:0]) << {addr_lo, 3'b000};
      end
      `EXE_ST_H: begin
        // Upper or lower half picked by address bit 1
        byte_en = addr_lo[1] ? 4'b1100 : 4'b0011;
        wdata   = addr_lo[1] ? {rt_data[15:0], 16'd0} : {16'd0, rt_data[15:0]};
      end
      `EXE_ST_W: begin
        byte_en = 4'b1111;
        wdata   = rt_data;
      end
      `EXE_ST_NONE: begin
        byte_en = '0;
      end
      default: begin
        byte_en = '0;
      end
    endcase
  end

  always_comb begin
    case (store_kind)
      `EXE_ST_B: size = 3'd0;
      `EXE_ST_H: size = 3'd1;
      `EXE_ST_W: size = 3'd2;
      default: begin
        case (load_kind)
          `EXE_LD_B, `EXE_LD_BU: size = 3'd0;
          `EXE_LD_H, `EXE_LD_HU: size = 3'd1;
          `EXE_LD_W:             size = 3'd2;
          `EXE_LD_NONE:          size = 3'd0;
          default:               size = 3'd0;
        endcase
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Address errors
  ////////////////////////////////////////////////////////////

  assign ld_half = (load_kind == `EXE_LD_H) || (load_kind == `EXE_LD_HU);
  assign ld_word = (load_kind == `EXE_LD_W);
  assign st_half = (store_kind == `EXE_ST_H);
  assign st_word = (store_kind == `EXE_ST_W);

  assign adel = (ld_half && addr_lo[0]) || (ld_word && (addr_lo != 2'd0));
  assign ades = (st_half && addr_lo[0]) || (st_word && (addr_lo != 2'd0));

  // A non-store must never reach memory as a write
  always_comb begin
    assert ((store_kind != `EXE_ST_NONE) || (byte_en == '0))
      else $error("store_align: byte enables set with no store");
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it once
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f compile.f --top-module tb_execute_stage -o sim_execute_stage

./obj_dir/sim_execute_stage | tee sim.log

if grep -qx "Regression passed" sim.log; then
  echo "Simulation result: PASS"
  exit 0
else
  echo "Simulation result: FAIL"
  exit 1
fi

/* verif/tb_execute_stage.sv */
// Needs rtl/ on the include path and a simulator with timing support; stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

`include "exe_params.svh"

module tb_execute_stage;

  // One table row, stimulus plus what the memory stage must see
  typedef struct packed {
    exe_pkg::id_exe_t   id;
    exe_pkg::word_t     result;
    exe_pkg::byte_en_t  byte_en;
    exe_pkg::word_t     wdata;
    exe_pkg::acc_size_t size;
    exe_pkg::exc_vec_t  exc;
  } row_t;

  logic              clk;
  logic              rst;
  logic              in_valid;
  logic              allowin;
  exe_pkg::id_exe_t  id_in;
  logic              out_valid;
  logic              mem_allowin;
  exe_pkg::exe_mem_t mem_out;

  row_t             table_q[$];
  exe_pkg::id_exe_t base;
  logic             table_ready = 1'b0;

  execute_stage i_dut (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .allowin     (allowin),
    .id_in       (id_in),
    .out_valid   (out_valid),
    .mem_allowin (mem_allowin),
    .mem_out     (mem_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Error handling and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "Stopping after the first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input exe_pkg::word_t got,
                            input exe_pkg::word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_byte_en(input string name, input exe_pkg::byte_en_t got,
                               input exe_pkg::byte_en_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_size(input string name, input exe_pkg::acc_size_t got,
                            input exe_pkg::acc_size_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_exc(input string name, input exe_pkg::exc_vec_t got,
                           input exe_pkg::exc_vec_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_bundle(input string name, input exe_pkg::exe_mem_t got,
                              input exe_pkg::exe_mem_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // Whole bundle for a row, decode fields carried through as they were sent
  function automatic exe_pkg::exe_mem_t expected_out(input row_t r);
    exe_pkg::exe_mem_t e;
    e.pc         = r.id.pc;
    e.alu_result = r.result;
    e.mem_wdata  = r.wdata;
    e.rt_data    = r.id.rt_data;
    e.byte_en    = r.byte_en;
    e.addr_lo    = r.result[1:0];
    e.acc_size   = r.size;
    e.mem_en     = r.id.mem_en;
    e.mem_to_reg = r.id.mem_to_reg;
    e.reg_wen    = r.id.reg_wen;
    e.reg_waddr  = r.id.reg_waddr;
    e.load_kind  = r.id.load_kind;
    e.delay_slot = r.id.delay_slot;
    e.exc        = r.exc;
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // Table construction
  ////////////////////////////////////////////////////////////

  task automatic set_operands(input exe_pkg::word_t rs, input exe_pkg::word_t rt,
                              input exe_pkg::word_t sa, input exe_pkg::word_t sext,
                              input exe_pkg::word_t zext);
    base          = '0;
    base.pc       = 32'h0040_1000;
    base.pc_plus4 = 32'h0040_1004;
    base.rs_data  = rs;
    base.rt_data  = rt;
    base.sa       = sa;
    base.sext_imm = sext;
    base.zext_imm = zext;
  endtask

  task automatic push_row(input exe_pkg::id_exe_t id, input exe_pkg::word_t res,
                          input exe_pkg::byte_en_t be, input exe_pkg::word_t wd,
                          input exe_pkg::acc_size_t sz, input exe_pkg::exc_vec_t exc);
    row_t r;
    int   n;
    n       = table_q.size();
    r.id    = id;
    // Tag each row so a lost or swapped writeback field shows up
    r.id.reg_waddr  = exe_pkg::reg_addr_t'(n + 1);
    r.id.reg_wen    = n[3:0];
    r.id.delay_slot = n[0];
    r.id.mem_to_reg = n[1];
    r.result  = res;
    r.byte_en = be;
    r.wdata   = wd;
    r.size    = sz;
    r.exc     = exc;
    table_q.push_back(r);
  endtask

  task automatic alu_row(input exe_pkg::alu_op_t op, input exe_pkg::src_sel_t sel_a,
                         input exe_pkg::src_sel_t sel_b, input logic sgn,
                         input exe_pkg::word_t res, input exe_pkg::exc_vec_t exc);
    exe_pkg::id_exe_t id;
    id           = base;
    id.alu_op    = op;
    id.src_a     = sel_a;
    id.src_b     = sel_b;
    id.is_signed = sgn;
    push_row(id, res, 4'b0000, 32'h0, 3'd0, exc);
  endtask

  // Address is 0x1000_0000 plus a small offset, store data 0x1122_3344
  task automatic mem_row(input exe_pkg::store_kind_t st, input exe_pkg::load_kind_t ld,
                         input logic [1:0] off, input exe_pkg::byte_en_t be,
                         input exe_pkg::word_t wd, input exe_pkg::acc_size_t sz,
                         input exe_pkg::exc_vec_t exc);
    exe_pkg::id_exe_t id;
    id            = base;
    id.alu_op     = `EXE_ALU_ADD;
    id.src_a      = `EXE_SRCA_RS;
    id.src_b      = `EXE_SRCB_SEXT;
    id.rs_data    = 32'h1000_0000;
    id.sext_imm   = {30'd0, off};
    id.rt_data    = 32'h1122_3344;
    id.store_kind = st;
    id.load_kind  = ld;
    id.mem_en     = 1'b1;
    push_row(id, {30'h0400_0000, off}, be, wd, sz, exc);
  endtask

  task automatic flag_row(input exe_pkg::id_exc_t flags, input exe_pkg::word_t res,
                          input exe_pkg::exc_vec_t exc);
    exe_pkg::id_exe_t id;
    id        = base;
    id.alu_op = `EXE_ALU_ADD;
    id.id_exc = flags;
    push_row(id, res, 4'b0000, 32'h0, 3'd0, exc);
  endtask

  task automatic make_table();
    // Each source select shows up at least once
    set_operands(32'h0000_1234, 32'h0000_0010, 32'h0000_0003, 32'hFFFF_FFF0, 32'h0000_FFF0);
    alu_row(`EXE_ALU_ADD, `EXE_SRCA_RS, `EXE_SRCB_RT, 1'b0, 32'h0000_1244, 7'h00);
    alu_row(`EXE_ALU_ADD, `EXE_SRCA_PC4, `EXE_SRCB_FOUR, 1'b0, 32'h0040_1008, 7'h00);
    alu_row(`EXE_ALU_ADD, `EXE_SRCA_RS, `EXE_SRCB_SEXT, 1'b1, 32'h0000_1224, 7'h00);
    alu_row(`EXE_ALU_OR, `EXE_SRCA_ZERO, `EXE_SRCB_ZEXT, 1'b0, 32'h0000_FFF0, 7'h00);
    alu_row(`EXE_ALU_SUB, `EXE_SRCA_RS, `EXE_SRCB_RT, 1'b1, 32'h0000_1224, 7'h00);
    alu_row(`EXE_ALU_SUB, `EXE_SRCA_SA, `EXE_SRCB_RT, 1'b1, 32'hFFFF_FFF3, 7'h00);
    alu_row(`EXE_ALU_AND, `EXE_SRCA_RS, `EXE_SRCB_ZEXT, 1'b0, 32'h0000_1230, 7'h00);
    set_operands(32'hF0F0_1234, 32'h0FF0_00FF, 32'h0000_0004, 32'h0, 32'h0);
    alu_row(`EXE_ALU_AND, `EXE_SRCA_RS, `EXE_SRCB_RT, 1'b0, 32'h00F0_0034, 7'h00);
    alu_row(`EXE_ALU_OR, `EXE_SRCA_RS, `EXE_SRCB_RT, 1'b0, 32'hFFF0_12FF, 7'h00);
    alu_row(`EXE_ALU_XOR, `EXE_SRCA_RS, `EXE_SRCB_RT, 1'b0, 32'hFF00_12CB, 7'h00);
    alu_row(`EXE_ALU_NOR, `EXE_SRCA_RS, `EXE_SRCB_RT, 1'b0, 32'h000F_ED00, 7'h00);
    set_operands(32'hFFFF_FFFF, 32'h0000_0001, 32'h0, 32'h0, 32'h0);
    alu_row(`EXE_ALU_SLT, `EXE_SRCA_RS, `EXE_SRCB_RT, 1'b0, 32'h0000_0001, 7'h00);
    alu_row(`EXE_ALU_SLTU, `EXE_SRCA_RS, `EXE_SRCB_RT, 1'b0, 32'h0000_0000, 7'h00);
    // Shift amount 0x24 keeps only its low five bits
    set_operands(32'h0, 32'h8000_0F0F, 32'h0000_0024, 32'h0, 32'h0000_ABCD);
    alu_row(`EXE_ALU_SLL, `EXE_SRCA_SA, `EXE_SRCB_RT, 1'b0, 32'h0000_F0F0, 7'h00);
    alu_row(`EXE_ALU_SRL, `EXE_SRCA_SA, `EXE_SRCB_RT, 1'b0, 32'h0800_00F0, 7'h00);
    alu_row(`EXE_ALU_SRA, `EXE_SRCA_SA, `EXE_SRCB_RT, 1'b0, 32'hF800_00F0, 7'h00);
    alu_row(`EXE_ALU_LUI, `EXE_SRCA_ZERO, `EXE_SRCB_ZEXT, 1'b0, 32'hABCD_0000, 7'h00);
    // Overflow only for the signed forms
    set_operands(32'h7FFF_FFFF, 32'h0000_0001, 32'h0, 32'h0, 32'h0);
    alu_row(`EXE_ALU_ADD, `EXE_SRCA_RS, `EXE_SRCB_RT, 1'b1, 32'h8000_0000, 7'h10);
    alu_row(`EXE_ALU_ADD, `EXE_SRCA_RS, `EXE_SRCB_RT, 1'b0, 32'h8000_0000, 7'h00);
    set_operands(32'h8000_0000, 32'h0000_0001, 32'h0, 32'h0, 32'h0);
    alu_row(`EXE_ALU_SUB, `EXE_SRCA_RS, `EXE_SRCB_RT, 1'b1, 32'h7FFF_FFFF, 7'h10);
    alu_row(`EXE_ALU_SUB, `EXE_SRCA_RS, `EXE_SRCB_RT, 1'b0, 32'h7FFF_FFFF, 7'h00);
    // Stores and loads, aligned and not
    mem_row(`EXE_ST_B, `EXE_LD_NONE, 2'd0, 4'b0001, 32'h0000_0044, 3'd0, 7'h00);
    mem_row(`EXE_ST_B, `EXE_LD_NONE, 2'd1, 4'b0010, 32'h0000_4400, 3'd0, 7'h00);
    mem_row(`EXE_ST_B, `EXE_LD_NONE, 2'd2, 4'b0100, 32'h0044_0000, 3'd0, 7'h00);
    mem_row(`EXE_ST_B, `EXE_LD_NONE, 2'd3, 4'b1000, 32'h4400_0000, 3'd0, 7'h00);
    mem_row(`EXE_ST_H, `EXE_LD_NONE, 2'd0, 4'b0011, 32'h0000_3344, 3'd1, 7'h00);
    mem_row(`EXE_ST_H, `EXE_LD_NONE, 2'd2, 4'b1100, 32'h3344_0000, 3'd1, 7'h00);
    mem_row(`EXE_ST_W, `EXE_LD_NONE, 2'd0, 4'b1111, 32'h1122_3344, 3'd2, 7'h00);
    mem_row(`EXE_ST_NONE, `EXE_LD_H, 2'd1, 4'b0000, 32'h0, 3'd1, 7'h02);
    mem_row(`EXE_ST_NONE, `EXE_LD_W, 2'd2, 4'b0000, 32'h0, 3'd2, 7'h02);
    mem_row(`EXE_ST_NONE, `EXE_LD_W, 2'd0, 4'b0000, 32'h0, 3'd2, 7'h00);
    mem_row(`EXE_ST_NONE, `EXE_LD_BU, 2'd3, 4'b0000, 32'h0, 3'd0, 7'h00);
    mem_row(`EXE_ST_H, `EXE_LD_NONE, 2'd3, 4'b1100, 32'h3344_0000, 3'd1, 7'h01);
    mem_row(`EXE_ST_W, `EXE_LD_NONE, 2'd1, 4'b1111, 32'h1122_3344, 3'd2, 7'h01);
    // Decode flags land in their own bits
    set_operands(32'h0000_1234, 32'h0000_0010, 32'h0, 32'h0, 32'h0);
    flag_row(4'b1000, 32'h0000_1244, 7'h40);
    flag_row(4'b0100, 32'h0000_1244, 7'h20);
    flag_row(4'b0010, 32'h0000_1244, 7'h08);
    flag_row(4'b0001, 32'h0000_1244, 7'h04);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus, output checks and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    int   sent;
    int   taken;
    logic stalled;
    exe_pkg::exe_mem_t held;
    row_t exp_row;
    void'($urandom(32'h84ad_d901));
    rst         = 1'b1;
    in_valid    = 1'b0;
    id_in       = '0;
    mem_allowin = 1'b0;
    make_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    #2;
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("allowin", allowin, 1'b1);
    check_bundle("mem_out", mem_out, '0);
    sent    = 0;
    taken   = 0;
    stalled = 1'b0;
    held    = '0;
    while (taken < table_q.size()) begin
      @(posedge clk);
      #1;
      mem_allowin = ($urandom % 4) != 0;
      if (sent < table_q.size()) begin
        in_valid = 1'b1;
        id_in    = table_q[sent].id;
      end else begin
        in_valid = 1'b0;
        id_in    = '0;
      end
      // Sample midway between edges, where everything has settled
      #2;
      // One entry, one cycle of latency
      check_flag("out_valid", out_valid, sent > taken);
      check_flag("allowin", allowin, (sent == taken) || mem_allowin);
      if (stalled) begin
        check_bundle("mem_out", mem_out, held);
      end
      if (out_valid === 1'b1) begin
        if (mem_allowin) begin
          exp_row = table_q[taken];
          check_word("alu_result", mem_out.alu_result, exp_row.result);
          check_byte_en("byte_en", mem_out.byte_en, exp_row.byte_en);
          check_word("mem_wdata", mem_out.mem_wdata, exp_row.wdata);
          check_size("acc_size", mem_out.acc_size, exp_row.size);
          check_exc("exc", mem_out.exc, exp_row.exc);
          check_bundle("mem_out", mem_out, expected_out(exp_row));
          taken++;
          stalled = 1'b0;
        end else begin
          held    = mem_out;
          stalled = 1'b1;
        end
      end
      if (in_valid && allowin) sent++;
    end
    // Nothing may follow the last row
    @(posedge clk);
    #1;
    in_valid    = 1'b0;
    mem_allowin = 1'b1;
    #2;
    check_flag("out_valid", out_valid, 1'b0);
    $display("Regression passed");
    $finish;
  end

  initial begin
    wait (table_ready === 1'b1);
    repeat (table_q.size() * 20 + 8) @(posedge clk);
    abort_run("Timeout: the table rows did not all leave the stage in time");
  end

endmodule

`default_nettype wire
